// File: nocTorus.f
+incdir+source
source/nocTorusPkg.sv
source/linkIf.sv
source/portFifo.sv
source/routeCompute.sv
source/routerControl.sv
source/router.sv
source/networkTorus.sv
test/networkTorus_assert.sv
test/networkTorus_tb.sv

// File: test/networkTorus_tests.txt
// Columns in hex: test number, source node, destination node, payload, eject-stall flag
// Several records per line, node is x plus 3 times y, a zero test number ends the list
// Test 1: centre node to its four neighbours and itself
1 4 1 10041 0  1 4 3 10043 0  1 4 5 10045 0  1 4 7 10047 0  1 4 4 10044 0
// Test 2: wraparound paths
2 0 2 20002 0  2 0 6 20006 0
// Test 3: all to all
3 0 1 301 0  3 0 2 302 0  3 0 3 303 0  3 0 4 304 0  3 0 5 305 0  3 0 6 306 0
3 0 7 307 0  3 0 8 308 0  3 1 0 310 0  3 1 2 312 0  3 1 3 313 0  3 1 4 314 0
3 1 5 315 0  3 1 6 316 0  3 1 7 317 0  3 1 8 318 0  3 2 0 320 0  3 2 1 321 0
3 2 3 323 0  3 2 4 324 0  3 2 5 325 0  3 2 6 326 0  3 2 7 327 0  3 2 8 328 0
3 3 0 330 0  3 3 1 331 0  3 3 2 332 0  3 3 4 334 0  3 3 5 335 0  3 3 6 336 0
3 3 7 337 0  3 3 8 338 0  3 4 0 340 0  3 4 1 341 0  3 4 2 342 0  3 4 3 343 0
3 4 5 345 0  3 4 6 346 0  3 4 7 347 0  3 4 8 348 0  3 5 0 350 0  3 5 1 351 0
3 5 2 352 0  3 5 3 353 0  3 5 4 354 0  3 5 6 356 0  3 5 7 357 0  3 5 8 358 0
3 6 0 360 0  3 6 1 361 0  3 6 2 362 0  3 6 3 363 0  3 6 4 364 0  3 6 5 365 0
3 6 7 367 0  3 6 8 368 0  3 7 0 370 0  3 7 1 371 0  3 7 2 372 0  3 7 3 373 0
3 7 4 374 0  3 7 5 375 0  3 7 6 376 0  3 7 8 378 0  3 8 0 380 0  3 8 1 381 0
3 8 2 382 0  3 8 3 383 0  3 8 4 384 0  3 8 5 385 0  3 8 6 386 0  3 8 7 387 0
// Test 4: in-order delivery per pair
4 0 8 40801 0  4 0 8 40802 0  4 0 8 40803 0  4 0 8 40804 0  4 0 8 40805 0
4 5 1 45101 0  4 5 1 45102 0  4 5 1 45103 0
// Test 5: eject credits withheld for random times
5 0 4 50041 1  5 1 4 50141 1  5 2 4 50241 1  5 3 4 50341 1  5 5 4 50541 1
5 6 4 50641 1  5 8 4 50841 1  5 8 4 50842 1  5 8 0 50801 1  5 8 0 50802 1
0 0 0 0 0

// File: test/networkTorus_tb.sv
// Testbench for the torus NoC with file-driven traffic and ejection checks
// Local inject and eject credit models per node, router assertions bound in

`default_nettype none

`include "nocTorus_defs.svh"

module networkTorus_tb;

  import nocTorusPkg::*;

  localparam int NODES    = `NOC_X_NODES * `NOC_Y_NODES;
  localparam int MAX_RECS = 128;
  localparam int PERIOD   = 8;
  localparam int SETTLE   = 30;

  bind routerControl networkTorus_assert u_assert
    (.clk      (clk),
     .reset    (reset),
     .creditIn ({outLink[4].credit, outLink[3].credit, outLink[2].credit,
                 outLink[1].credit, outLink[0].credit}),
     .validOut ({gOut[4].sendValid, gOut[3].sendValid, gOut[2].sendValid,
                 gOut[1].sendValid, gOut[0].sendValid}),
     .credits  ({gOut[4].credits, gOut[3].credits, gOut[2].credits,
                 gOut[1].credits, gOut[0].credits}));

  logic                          clk;
  logic                          reset;
  logic                          injectValid   [NODES];
  nodeCoord_t                    injectDest    [NODES];
  logic [`NOC_PAYLOAD_WIDTH-1:0] injectPayload [NODES];
  logic                          injectCredit  [NODES];
  logic                          ejectValid    [NODES];
  nodeCoord_t                    ejectSrc      [NODES];
  logic [`NOC_PAYLOAD_WIDTH-1:0] ejectPayload  [NODES];
  logic                          ejectCredit   [NODES];

  // Raw file words, five per record
  logic [31:0]                   recWords  [MAX_RECS*5];
  int                            recTest   [MAX_RECS];
  int                            recSrc    [MAX_RECS];
  int                            recDst    [MAX_RECS];
  logic [`NOC_PAYLOAD_WIDTH-1:0] recPay    [MAX_RECS];
  int                            recStall  [MAX_RECS];
  bit                            delivered [MAX_RECS];
  int                            numRecs = 0;
  bit                            loaded  = 1'b0;

  // Record window of the running test
  int firstRec = 0;
  int lastRec  = -1;
  bit running  = 1'b0;

  // Credit models and pending eject credit returns
  int injCredits [NODES];
  int ejCredits  [NODES];
  int injNext    [NODES];
  int due        [NODES][4];
  int dueCnt     [NODES];

  int cycle      = 0;
  int errors     = 0;
  int checks     = 0;
  int delivCount = 0;
  int ejectCount = 0;

  networkTorus u_networkTorus
    (.clk           (clk),
     .reset         (reset),
     .injectValid   (injectValid),
     .injectDest    (injectDest),
     .injectPayload (injectPayload),
     .injectCredit  (injectCredit),
     .ejectValid    (ejectValid),
     .ejectSrc      (ejectSrc),
     .ejectPayload  (ejectPayload),
     .ejectCredit   (ejectCredit));

  always #(PERIOD / 2) clk = ~clk;

  function automatic nodeCoord_t nodeToCoord(input int n);
    nodeCoord_t c;
    c.x = `NOC_COORD_WIDTH'(n % `NOC_X_NODES);
    c.y = `NOC_COORD_WIDTH'(n / `NOC_X_NODES);
    return c;
  endfunction

  // Out-of-grid coordinates map to no node
  function automatic int coordToNode(input nodeCoord_t c);
    if (c.x >= `NOC_X_NODES || c.y >= `NOC_Y_NODES)
      return -1;
    return int'(c.x) + `NOC_X_NODES * int'(c.y);
  endfunction

  task automatic checkFlit(input int n,
                           input nodeCoord_t expSrc,
                           input nodeCoord_t actSrc,
                           input logic [`NOC_PAYLOAD_WIDTH-1:0] expPay,
                           input logic [`NOC_PAYLOAD_WIDTH-1:0] actPay);
    checks++;
    if (actSrc !== expSrc)
      begin
        errors++;
        $display("[ERROR] t=%0t ejectSrc[%0d] expected (%0d,%0d) actual (%0d,%0d)",
                 $time, n, expSrc.x, expSrc.y, actSrc.x, actSrc.y);
      end
    if (actPay !== expPay)
      begin
        errors++;
        $display("[ERROR] t=%0t ejectPayload[%0d] expected %h actual %h",
                 $time, n, expPay, actPay);
      end
  endtask

  task automatic checkCount(input int t, input int expCount, input int actCount);
    checks++;
    if (actCount != expCount)
      begin
        errors++;
        $display("[ERROR] t=%0t ejectCount of test %0d expected %0d actual %0d",
                 $time, t, expCount, actCount);
      end
  endtask

  task automatic checkLow(input string name, input int n, input logic act);
    checks++;
    if (act !== 1'b0)
      begin
        errors++;
        $display("[ERROR] t=%0t %s[%0d] expected 0 actual %b", $time, name, n, act);
      end
  endtask

  task automatic loadTests();
    $readmemh("test/networkTorus_tests.txt", recWords);
    // Test number zero closes the list
    while (numRecs < MAX_RECS && !$isunknown(recWords[5*numRecs]) &&
           recWords[5*numRecs] != 0)
      begin
        recTest[numRecs]  = recWords[5*numRecs];
        recSrc[numRecs]   = recWords[5*numRecs + 1];
        recDst[numRecs]   = recWords[5*numRecs + 2];
        recPay[numRecs]   = recWords[5*numRecs + 3];
        recStall[numRecs] = recWords[5*numRecs + 4];
        numRecs++;
      end
    loaded = 1'b1;
  endtask

  // Match one ejected flit and schedule its credit return
  task automatic acceptFlit(input int n);
    int p;
    int r;
    int delay;
    p     = -1;
    r     = -1;
    delay = 1;
    ejectCount++;
    if (ejCredits[n] == 0)
      begin
        errors++;
        $display("Node %0d ejected a flit at time %0t while holding no eject credit",
                 n, $time);
      end
    else
      ejCredits[n]--;
    // Payload names the flit, its pair's oldest open record is the one expected
    for (int i = firstRec; i <= lastRec; i++)
      if (p < 0 && !delivered[i] && recDst[i] == n && recPay[i] == ejectPayload[n])
        p = i;
    if (p >= 0)
      for (int i = firstRec; i <= lastRec; i++)
        if (r < 0 && !delivered[i] && recSrc[i] == recSrc[p] && recDst[i] == n)
          r = i;
    if (r < 0)
      begin
        errors++;
        $display("Node %0d ejected an unexpected flit from node %0d at time %0t",
                 n, coordToNode(ejectSrc[n]), $time);
      end
    else
      begin
        checkFlit(n, nodeToCoord(recSrc[r]), ejectSrc[n], recPay[r], ejectPayload[n]);
        delivered[p] = 1'b1;
        delivCount++;
        if (recStall[p] != 0)
          delay = 4 + $urandom % 24;
      end
    if (dueCnt[n] < 4)
      begin
        due[n][dueCnt[n]] = cycle + delay;
        dueCnt[n]++;
      end
  endtask

  task automatic reportTest(input int t, input int expCount, input int actCount,
                            input int errorsBefore);
    $display("Test %0d: %0d of %0d flits delivered, %s", t, actCount, expCount,
             (errors == errorsBefore) ? "ok" : "errors seen");
  endtask

  // Local ports of every node, inputs change on the rising edge only
  always @(posedge clk)
    begin : traffic
      int r;
      int k;
      cycle++;
      for (int n = 0; n < NODES; n++)
        begin
          injectValid[n] <= 1'b0;
          ejectCredit[n] <= 1'b0;
          if (!reset)
            begin
              if (injectCredit[n])
                injCredits[n]++;
              // Next record of the running test sourced here
              while (injNext[n] <= lastRec && recSrc[injNext[n]] != n)
                injNext[n]++;
              if (running && injNext[n] <= lastRec && injCredits[n] > 0)
                begin
                  r = injNext[n];
                  injectValid[n]   <= 1'b1;
                  injectDest[n]    <= nodeToCoord(recDst[r]);
                  injectPayload[n] <= recPay[r];
                  injCredits[n]--;
                  injNext[n]++;
                end
              // At most one eject credit pulse per cycle
              k = 0;
              while (k < dueCnt[n] && due[n][k] > cycle)
                k++;
              if (k < dueCnt[n])
                begin
                  ejectCredit[n] <= 1'b1;
                  ejCredits[n]++;
                  for (int j = k; j < dueCnt[n] - 1; j++)
                    due[n][j] = due[n][j + 1];
                  dueCnt[n]--;
                end
              if (ejectValid[n])
                acceptFlit(n);
            end
        end
    end

  initial
    begin : watchdog
      wait (loaded);
      repeat (200 * numRecs) @(posedge clk);
      $display("Watchdog expired after %0d cycles with flits still undelivered",
               200 * numRecs);
      $display("*** TEST FAILED ***");
      $finish;
    end

  initial
    begin : main
      int seedValue;
      int t;
      int expCount;
      int errorsBefore;
      int testsRun;
      seedValue = $urandom(32'hd83a2e31);
      clk       = 1'b0;
      reset    <= 1'b1;
      for (int n = 0; n < NODES; n++)
        begin
          injectValid[n]   <= 1'b0;
          injectDest[n]    <= '0;
          injectPayload[n] <= '0;
          ejectCredit[n]   <= 1'b0;
          injCredits[n]     = `NOC_FIFO_DEPTH;
          ejCredits[n]      = `NOC_FIFO_DEPTH;
          injNext[n]        = 0;
          dueCnt[n]         = 0;
        end
      loadTests();
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      // Idle network, nothing injected
      @(negedge clk);
      errorsBefore = errors;
      repeat (10)
        begin
          @(negedge clk);
          for (int n = 0; n < NODES; n++)
            begin
              checkLow("injectCredit", n, injectCredit[n]);
              checkLow("ejectValid", n, ejectValid[n]);
            end
        end
      reportTest(0, 0, 0, errorsBefore);
      testsRun = 1;

      // Records of one test sit next to each other in the file
      while (firstRec < numRecs)
        begin
          t       = recTest[firstRec];
          lastRec = firstRec;
          while (lastRec + 1 < numRecs && recTest[lastRec + 1] == t)
            lastRec++;
          expCount     = lastRec - firstRec + 1;
          errorsBefore = errors;
          delivCount   = 0;
          ejectCount   = 0;
          for (int n = 0; n < NODES; n++)
            injNext[n] = firstRec;
          running = 1'b1;
          while (delivCount < expCount)
            @(negedge clk);
          running = 1'b0;
          // Late duplicates show up as extra ejections
          repeat (SETTLE) @(negedge clk);
          checkCount(t, expCount, ejectCount);
          reportTest(t, expCount, delivCount, errorsBefore);
          testsRun++;
          firstRec = lastRec + 1;
        end

      $display("Summary: %0d tests, %0d checks, %0d errors", testsRun, checks, errors);
      if (errors == 0)
        $display("*** TEST PASSED ***");
      else
        $display("*** TEST FAILED ***");
      $finish;
    end

endmodule

`default_nettype wire

// File: test/networkTorus_assert.sv
// Concurrent checks on router output credits and output valid
// Bound into every router control block

`default_nettype none

`include "nocTorus_defs.svh"

module networkTorus_assert
  #(parameter int CNT_W = $clog2(`NOC_FIFO_DEPTH + 1))
   (input logic               clk,
    input logic               reset,
    input logic [4:0]         creditIn,
    input logic [4:0]         validOut,
    input logic [5*CNT_W-1:0] credits);

  for (genvar o = 0; o < 5; o++)
    begin : gOut
      // Flits sent on the link and not yet credited back
      logic [CNT_W-1:0] inFlight;

      always_ff @(posedge clk)
        if (reset)
          inFlight <= '0;
        else
          inFlight <= inFlight + CNT_W'(validOut[o]) - CNT_W'(creditIn[o]);

      // A send needs a free slot in the downstream FIFO
      assert property (@(posedge clk) disable iff (reset)
                       validOut[o] |-> inFlight < CNT_W'(`NOC_FIFO_DEPTH))
        else $error("Output %0d sent a flit with no free downstream slot", o);

      // Counter is bounded by the downstream FIFO depth
      assert property (@(posedge clk) disable iff (reset)
                       credits[o*CNT_W +: CNT_W] <= CNT_W'(`NOC_FIFO_DEPTH))
        else $error("Output %0d credit counter above FIFO depth", o);
    end

  // Output registers come out of reset idle
  assert property (@(posedge clk) reset |=> validOut == '0)
    else $error("Output valid high in the cycle after reset");

endmodule

`default_nettype wire

// File: source/networkTorus.sv
// Top level 3 by 3 torus of routers with wraparound links
// Local inject and eject ports per node

`default_nettype none

`include "nocTorus_defs.svh"

module networkTorus
  (input  logic                          clk,
   input  logic                          reset,
   input  logic                          injectValid   [`NOC_X_NODES*`NOC_Y_NODES],
   input  nocTorusPkg::nodeCoord_t       injectDest    [`NOC_X_NODES*`NOC_Y_NODES],
   input  logic [`NOC_PAYLOAD_WIDTH-1:0] injectPayload [`NOC_X_NODES*`NOC_Y_NODES],
   output logic                          injectCredit  [`NOC_X_NODES*`NOC_Y_NODES],
   output logic                          ejectValid    [`NOC_X_NODES*`NOC_Y_NODES],
   output nocTorusPkg::nodeCoord_t       ejectSrc      [`NOC_X_NODES*`NOC_Y_NODES],
   output logic [`NOC_PAYLOAD_WIDTH-1:0] ejectPayload  [`NOC_X_NODES*`NOC_Y_NODES],
   input  logic                          ejectCredit   [`NOC_X_NODES*`NOC_Y_NODES]);

  localparam int XN = `NOC_X_NODES;
  localparam int YN = `NOC_Y_NODES;

  for (genvar y = 0; y < YN; y++)
    begin : gRow
      for (genvar x = 0; x < XN; x++)
        begin : gCol
          // Node number x plus 3 times y
          localparam int NODE = x + XN * y;
          localparam logic [`NOC_COORD_WIDTH-1:0] X_COORD = x;
          localparam logic [`NOC_COORD_WIDTH-1:0] Y_COORD = y;

          linkIf inLinks  [5] ();
          linkIf outLinks [5] ();

          router #(.X_POS(x), .Y_POS(y)) u_router
            (.clk     (clk),
             .reset   (reset),
             .inLink  (inLinks),
             .outLink (outLinks));

          // Neighbour in direction d, north is node plus 3, east is x plus 1
          for (genvar d = 0; d < 4; d++)
            begin : gDir
              localparam int NX  = (d == 1) ? (x + 1) % XN :
                                   (d == 3) ? (x + XN - 1) % XN : x;
              localparam int NY  = (d == 0) ? (y + 1) % YN :
                                   (d == 2) ? (y + YN - 1) % YN : y;
              localparam int OPP = (d + 2) % 4;

              // Flit in from the neighbour's facing output
              assign inLinks[d].valid   = gRow[NY].gCol[NX].outLinks[OPP].valid;
              assign inLinks[d].dest    = gRow[NY].gCol[NX].outLinks[OPP].dest;
              assign inLinks[d].src     = gRow[NY].gCol[NX].outLinks[OPP].src;
              assign inLinks[d].payload = gRow[NY].gCol[NX].outLinks[OPP].payload;
              // Credit back from the neighbour's facing input
              assign outLinks[d].credit = gRow[NY].gCol[NX].inLinks[OPP].credit;
            end

          // Local inject, source is this node
          assign inLinks[4].valid   = injectValid[NODE];
          assign inLinks[4].dest    = injectDest[NODE];
          assign inLinks[4].src     = '{x: X_COORD, y: Y_COORD};
          assign inLinks[4].payload = injectPayload[NODE];
          assign injectCredit[NODE] = inLinks[4].credit;

          // Local eject
          assign ejectValid[NODE]    = outLinks[4].valid;
          assign ejectSrc[NODE]      = outLinks[4].src;
          assign ejectPayload[NODE]  = outLinks[4].payload;
          assign outLinks[4].credit  = ejectCredit[NODE];
        end
    end

endmodule

`default_nettype wire

// File: source/router.sv
// Five-port torus router
// Input FIFOs and route units around one control block

`default_nettype none

module router
  #(parameter int X_POS = 0,
    parameter int Y_POS = 0)
   (input  logic     clk,
    input  logic     reset,
    linkIf.receiver  inLink  [5],
    linkIf.sender    outLink [5]);

  import nocTorusPkg::*;

  localparam int PORTS = 5;

  // Per-input datapath signals
  flit_t    inFlit    [PORTS];
  flit_t    headFlit  [PORTS];
  logic     empty     [PORTS];
  portDir_t outDir    [PORTS];
  logic     pop       [PORTS];
  logic     creditOut [PORTS];

  for (genvar i = 0; i < PORTS; i++)
    begin : gPort
      // Gather link fields into one flit
      assign inFlit[i] = '{dest:    inLink[i].dest,
                           src:     inLink[i].src,
                           payload: inLink[i].payload};

      portFifo u_fifo
        (.clk      (clk),
         .reset    (reset),
         .push     (inLink[i].valid),
         .pushFlit (inFlit[i]),
         .pop      (pop[i]),
         .headFlit (headFlit[i]),
         .empty    (empty[i]));

      // Route only the head flit
      routeCompute #(.X_POS(X_POS), .Y_POS(Y_POS)) u_route
        (.dest   (headFlit[i].dest),
         .outDir (outDir[i]));

      // Registered pop pulse returns a credit upstream
      assign inLink[i].credit = creditOut[i];
    end

  routerControl u_control
    (.clk       (clk),
     .reset     (reset),
     .headFlit  (headFlit),
     .empty     (empty),
     .outDir    (outDir),
     .pop       (pop),
     .creditOut (creditOut),
     .outLink   (outLink));

endmodule

`default_nettype wire

// File: source/routerControl.sv
// Round-robin output arbitration, credit counters and output registers
// Also pop and credit-return pulses for the five inputs

`default_nettype none

`include "nocTorus_defs.svh"

module routerControl
  (input  logic                  clk,
   input  logic                  reset,
   input  nocTorusPkg::flit_t    headFlit  [5],
   input  logic                  empty     [5],
   input  nocTorusPkg::portDir_t outDir    [5],
   output logic                  pop       [5],
   output logic                  creditOut [5],
   linkIf.sender                 outLink   [5]);

  import nocTorusPkg::*;

  localparam int PORTS = 5;
  localparam int CNT_W = $clog2(`NOC_FIFO_DEPTH + 1);

  // Grants indexed [output][input]
  logic [PORTS-1:0] grant    [PORTS];
  logic [2:0]       winner   [PORTS];
  logic             anyGrant [PORTS];

  for (genvar o = 0; o < PORTS; o++)
    begin : gOut
      logic [CNT_W-1:0] credits;
      logic [2:0]       rrPtr;
      logic             sendValid;
      flit_t            sendFlit;

      // Scan from the pointer, first requesting input wins
      always_comb
        begin : arbitrate
          int idx;
          grant[o]    = '0;
          winner[o]   = rrPtr;
          anyGrant[o] = 1'b0;
          for (int k = 0; k < PORTS; k++)
            begin
              idx = (int'(rrPtr) + k) % PORTS;
              if (!anyGrant[o] && credits != '0 && !empty[idx] &&
                  outDir[idx] == portDir_t'(o))
                begin
                  grant[o][idx] = 1'b1;
                  winner[o]     = 3'(idx);
                  anyGrant[o]   = 1'b1;
                end
            end
        end

      always_ff @(posedge clk)
        begin
          if (reset)
            begin
              credits   <= CNT_W'(`NOC_FIFO_DEPTH);
              rrPtr     <= NORTH;
              sendValid <= 1'b0;
            end
          else
            begin
              // One credit per send, one back per pulse from downstream
              credits   <= credits - CNT_W'(anyGrant[o]) + CNT_W'(outLink[o].credit);
              sendValid <= anyGrant[o];
              // Next scan starts after the winner
              if (anyGrant[o])
                rrPtr <= (winner[o] == 3'(PORTS - 1)) ? 3'd0 : winner[o] + 3'd1;
            end
        end

      // Output flit register
      always_ff @(posedge clk)
        if (anyGrant[o])
          sendFlit <= headFlit[winner[o]];

      assign outLink[o].valid   = sendValid;
      assign outLink[o].dest    = sendFlit.dest;
      assign outLink[o].src     = sendFlit.src;
      assign outLink[o].payload = sendFlit.payload;
    end

  // An input requests one output only, so at most one grant per input
  always_comb
    for (int i = 0; i < PORTS; i++)
      begin
        pop[i] = 1'b0;
        for (int o = 0; o < PORTS; o++)
          if (grant[o][i])
            pop[i] = 1'b1;
      end

  // Credit back to the upstream sender, one cycle after the pop
  always_ff @(posedge clk)
    for (int i = 0; i < PORTS; i++)
      if (reset)
        creditOut[i] <= 1'b0;
      else
        creditOut[i] <= pop[i];

endmodule

`default_nettype wire

// File: source/routeCompute.sv
// Dimension-ordered torus route decision for one head flit

`default_nettype none

`include "nocTorus_defs.svh"

module routeCompute
  #(parameter int X_POS = 0,
    parameter int Y_POS = 0)
   (input  nocTorusPkg::nodeCoord_t dest,
    output nocTorusPkg::portDir_t   outDir);

  import nocTorusPkg::*;

  localparam int XN = `NOC_X_NODES;
  localparam int YN = `NOC_Y_NODES;

  // Hops needed going the increasing way round each ring
  int xFwd;
  int yFwd;

  assign xFwd = (int'(dest.x) + XN - X_POS) % XN;
  assign yFwd = (int'(dest.y) + YN - Y_POS) % YN;

  always_comb
    begin
      // X first, tie goes east
      if (xFwd != 0)
        outDir = (xFwd <= XN - xFwd) ? EAST : WEST;
      // Then Y, the north link leads to the node with y plus one
      // Tie goes south
      else if (yFwd != 0)
        outDir = (yFwd < YN - yFwd) ? NORTH : SOUTH;
      // Arrived
      else
        outDir = LOCAL;
    end

endmodule

`default_nettype wire

// File: source/portFifo.sv
// Circular input FIFO of flits for one router port

`default_nettype none

`include "nocTorus_defs.svh"

module portFifo
  (input  logic               clk,
   input  logic               reset,
   input  logic               push,
   input  nocTorusPkg::flit_t pushFlit,
   input  logic               pop,
   output nocTorusPkg::flit_t headFlit,
   output logic               empty);

  import nocTorusPkg::*;

  localparam int DEPTH = `NOC_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Flit storage, no reset needed on payload
  flit_t            mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;

  // Pointer advance with wrap at the last slot
  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk)
    begin
      if (reset)
        begin
          wrPtr <= '0;
          rdPtr <= '0;
          count <= '0;
        end
      else
        begin
          if (push)
            wrPtr <= nextPtr(wrPtr);
          if (pop)
            rdPtr <= nextPtr(rdPtr);
          // Occupancy, push and pop may land together
          count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

  always_ff @(posedge clk)
    if (push)
      mem[wrPtr] <= pushFlit;

  // Head is visible the cycle after the write
  assign headFlit = mem[rdPtr];
  assign empty    = (count == '0);

endmodule

`default_nettype wire

// File: source/linkIf.sv
// One credit-controlled flit channel between two router ports

`default_nettype none

`include "nocTorus_defs.svh"

interface linkIf;

  import nocTorusPkg::*;

  // Forward path, one valid cycle per flit
  logic                          valid;
  nodeCoord_t                    dest;
  nodeCoord_t                    src;
  logic [`NOC_PAYLOAD_WIDTH-1:0] payload;

  // Return path, one pulse per flit popped at the receiver
  logic                          credit;

  modport sender   (output valid, dest, src, payload, input  credit);
  modport receiver (input  valid, dest, src, payload, output credit);

endinterface

`default_nettype wire

// File: source/nocTorusPkg.sv
// Coordinate, port direction and flit types shared by the torus NoC

`default_nettype none

`include "nocTorus_defs.svh"

package nocTorusPkg;

  // Node position in the torus
  typedef struct packed {
    logic [`NOC_COORD_WIDTH-1:0] x;
    logic [`NOC_COORD_WIDTH-1:0] y;
  } nodeCoord_t;

  // Router port numbering, also used as route decision
  typedef enum logic [2:0] {
    NORTH = 3'd0,
    EAST  = 3'd1,
    SOUTH = 3'd2,
    WEST  = 3'd3,
    LOCAL = 3'd4
  } portDir_t;

  // Single-flit packet, 40 bits
  typedef struct packed {
    nodeCoord_t                    dest;
    nodeCoord_t                    src;
    logic [`NOC_PAYLOAD_WIDTH-1:0] payload;
  } flit_t;

endpackage

`default_nettype wire

// File: source/nocTorus_defs.svh
// Grid size, FIFO depth and payload width macros for the torus NoC

`ifndef NOC_TORUS_DEFS_SVH
`define NOC_TORUS_DEFS_SVH

// Torus dimensions in nodes
`define NOC_X_NODES 3
`define NOC_Y_NODES 3

// Bits per coordinate, enough for 0 to 2
`define NOC_COORD_WIDTH 2

// Input FIFO slots per port
// Also the starting credit count of every sender
`define NOC_FIFO_DEPTH 4

// Flit payload width
`define NOC_PAYLOAD_WIDTH 32

`endif
